// File: canvas.f
design/canvas_pkg.sv
design/canvas_vram.sv
design/draw_engine.sv
design/row_fetch.sv
design/pixel_serializer.sv
design/canvas_top.sv
tb/canvas_tb.sv

// File: Bender.yml
package:
  name: canvas

sources:
  - files:
      - design/canvas_pkg.sv
      - design/canvas_vram.sv
      - design/draw_engine.sv
      - design/row_fetch.sv
      - design/pixel_serializer.sv
      - design/canvas_top.sv
  - target: test
    files:
      - tb/canvas_tb.sv

// File: tb/canvas_tb.sv
`timescale 1ns/100ps

module canvas_tb;
    import canvas_pkg::*;

    localparam int pixels     = canvas_dim * canvas_dim;
    localparam int scan_len   = pixels + 8;
    localparam int clear_len  = pixels + 4;
    localparam int test_len   = 4 * scan_len + 2 * clear_len + 40 * 3 + 8 * (canvas_dim + 3) + 20;
    localparam int max_cycles = test_len + 20000;

    logic               clk;
    logic               rst;
    logic               cmd_valid;
    draw_op_e           cmd_op;
    logic [coord_w-1:0] cmd_x;
    logic [coord_w-1:0] cmd_y;
    logic [coord_w-1:0] cmd_x_end;
    logic [pix_w-1:0]   cmd_color;
    logic               frame_start;
    logic               busy;
    logic               pix_valid;
    logic [coord_w-1:0] pix_x;
    logic [coord_w-1:0] pix_y;
    logic [pix_w-1:0]   pix_data;
    logic               scan_busy;

    // Expected contents of the frame buffer, indexed by y * 64 + x.
    logic [pix_w-1:0] model [0:pixels-1];
    logic [31:0]      lfsr_state;
    int               cycle_count;
    int               error_count;

    canvas_top uut (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_x       (cmd_x),
        .cmd_y       (cmd_y),
        .cmd_x_end   (cmd_x_end),
        .cmd_color   (cmd_color),
        .frame_start (frame_start),
        .busy        (busy),
        .pix_valid   (pix_valid),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_data    (pix_data),
        .scan_busy   (scan_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // Galois LFSR, stepped once for every bit handed out.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < n; i++) begin
            result = {result[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return result;
    endfunction

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    task automatic send_cmd(input draw_op_e op, input logic [coord_w-1:0] x, y, x_end,
                            input logic [pix_w-1:0] color);
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_x     = x;
        cmd_y     = y;
        cmd_x_end = x_end;
        cmd_color = color;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // Counts busy cycles after acceptance. Optionally strobes a plot mid-run.
    // The plot targets a pixel that the clear has already written.
    task automatic measure_busy(input bit inject, input logic [pix_w-1:0] plot_color,
                                output int len);
        len = 0;
        @(negedge clk);
        while (busy === 1'b1 && len < pixels + 16) begin
            len++;
            if (inject && (len == 100 || len == 101)) begin
                @(posedge clk);
                #1;
                cmd_valid = (len == 100);
                cmd_op    = op_plot;
                cmd_x     = 6'd7;
                cmd_y     = 6'd1;
                cmd_color = plot_color;
            end
            @(negedge clk);
        end
    endtask

    task automatic do_plot(input logic [coord_w-1:0] x, y, input logic [pix_w-1:0] color);
        send_cmd(op_plot, x, y, x, color);
        @(negedge clk);
        assert (busy === 1'b0)
            else report_mismatch("busy raised by a plot");
        model[int'(y) * canvas_dim + int'(x)] = color;
    endtask

    task automatic do_hline(input logic [coord_w-1:0] x, y, x_end,
                            input logic [pix_w-1:0] color);
        int len;
        int span;
        span = (x_end < x) ? 1 : int'(x_end) - int'(x) + 1;
        send_cmd(op_hline, x, y, x_end, color);
        measure_busy(1'b0, '0, len);
        assert (len == span)
            else report_mismatch($sformatf("hline busy %0d cycles, expected %0d", len, span));
        for (int i = 0; i < span; i++) begin
            model[int'(y) * canvas_dim + int'(x) + i] = color;
        end
    endtask

    task automatic do_clear(input logic [pix_w-1:0] color, input bit inject);
        int len;
        send_cmd(op_clear, '0, '0, '0, color);
        measure_busy(inject, ~color, len);
        assert (len == pixels)
            else report_mismatch($sformatf("clear busy %0d cycles, expected %0d", len, pixels));
        for (int a = 0; a < pixels; a++) begin
            model[a] = color;
        end
    endtask

    // Runs one frame and compares every pixel with the model in raster order.
    task automatic scan_frame(input bit restrike);
        int latency;
        assert (scan_busy === 1'b0)
            else report_mismatch("scan_busy high before frame start");
        @(posedge clk);
        #1;
        frame_start = 1'b1;
        @(posedge clk);
        #1;
        frame_start = 1'b0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (pix_valid !== 1'b1 && latency < 16);
        assert (latency == 3)
            else report_mismatch($sformatf("first pixel after %0d cycles, expected 3", latency));
        for (int i = 0; i < pixels; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            assert (pix_valid === 1'b1 && scan_busy === 1'b1)
                else report_mismatch($sformatf("pix_valid or scan_busy low at pixel %0d", i));
            assert (pix_x === coord_w'(i % canvas_dim) && pix_y === coord_w'(i / canvas_dim))
                else report_mismatch($sformatf("pixel %0d at x=%0d y=%0d", i, pix_x, pix_y));
            assert (pix_data === model[i])
                else report_mismatch($sformatf("pixel %0d data %h, expected %h",
                                               i, pix_data, model[i]));
            if (restrike && (i == 1000 || i == 1001)) begin
                @(posedge clk);
                #1;
                frame_start = (i == 1000);
            end
        end
        @(negedge clk);
        assert (pix_valid === 1'b0 && scan_busy === 1'b0)
            else report_mismatch("stream or scan_busy continued past the last pixel");
    endtask

    task automatic test_reset();
        @(negedge clk);
        assert (busy === 1'b0 && scan_busy === 1'b0 && pix_valid === 1'b0)
            else report_mismatch("outputs not idle after reset");
    endtask

    task automatic test_clear();
        do_clear(take_bits(8), 1'b0);
        scan_frame(1'b0);
    endtask

    task automatic test_plot();
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        logic [pix_w-1:0]   color;
        repeat (40) begin
            x     = take_bits(coord_w);
            y     = take_bits(coord_w);
            color = take_bits(pix_w);
            do_plot(x, y, color);
        end
        scan_frame(1'b0);
    endtask

    task automatic test_hline();
        do_hline(6'd5, 6'd10, 6'd40, take_bits(8));
        do_hline(6'd50, 6'd11, 6'd10, take_bits(8));
        do_hline(6'd20, 6'd12, 6'd20, take_bits(8));
        do_hline(6'd0, 6'd13, 6'd63, take_bits(8));
        repeat (4) begin
            do_hline(take_bits(6), take_bits(6), take_bits(6), take_bits(8));
        end
        scan_frame(1'b0);
    endtask

    // The plot and the second frame_start both land while their stage is busy.
    task automatic test_ignored();
        do_clear(take_bits(8), 1'b1);
        scan_frame(1'b1);
    endtask

    initial begin
        lfsr_state  = 32'h4b4a;
        error_count = 0;
        rst         = 1'b1;
        cmd_valid   = 1'b0;
        cmd_op      = op_plot;
        cmd_x       = '0;
        cmd_y       = '0;
        cmd_x_end   = '0;
        cmd_color   = '0;
        frame_start = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_clear();
        test_plot();
        test_hline();
        test_ignored();
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: design/canvas_top.sv
`timescale 1ns/100ps

module canvas_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cmd_valid,
    input  canvas_pkg::draw_op_e              cmd_op,
    input  logic [canvas_pkg::coord_w-1:0]    cmd_x,
    input  logic [canvas_pkg::coord_w-1:0]    cmd_y,
    input  logic [canvas_pkg::coord_w-1:0]    cmd_x_end,
    input  logic [canvas_pkg::pix_w-1:0]      cmd_color,
    input  logic                              frame_start,
    output logic                              busy,
    output logic                              pix_valid,
    output logic [canvas_pkg::coord_w-1:0]    pix_x,
    output logic [canvas_pkg::coord_w-1:0]    pix_y,
    output logic [canvas_pkg::pix_w-1:0]      pix_data,
    output logic                              scan_busy
);
    import canvas_pkg::*;

    logic               wr;
    logic [addr_w-1:0]  wr_addr;
    logic [pix_w-1:0]   wr_data;
    logic               rd;
    logic [coord_w-1:0] rd_row;
    logic [row_w-1:0]   row_data;
    logic               load;
    logic [coord_w-1:0] load_row;

    draw_engine u_draw (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_x     (cmd_x),
        .cmd_y     (cmd_y),
        .cmd_x_end (cmd_x_end),
        .cmd_color (cmd_color),
        .busy      (busy),
        .wr        (wr),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    canvas_vram u_vram (
        .clk      (clk),
        .wr       (wr),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd       (rd),
        .rd_row   (rd_row),
        .row_data (row_data)
    );

    row_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .rd          (rd),
        .rd_row      (rd_row),
        .load        (load),
        .load_row    (load_row),
        .scan_busy   (scan_busy)
    );

    pixel_serializer u_ser (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .load_row  (load_row),
        .row_data  (row_data),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pix_data  (pix_data)
    );

endmodule

// File: design/pixel_serializer.sv
`timescale 1ns/100ps

module pixel_serializer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              load,
    input  logic [canvas_pkg::coord_w-1:0]    load_row,
    input  logic [canvas_pkg::row_w-1:0]      row_data,
    output logic                              pix_valid,
    output logic [canvas_pkg::coord_w-1:0]    pix_x,
    output logic [canvas_pkg::coord_w-1:0]    pix_y,
    output logic [canvas_pkg::pix_w-1:0]      pix_data
);
    import canvas_pkg::*;

    logic [row_w-1:0] row_shift;

    assign pix_data = row_shift[pix_w-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
            pix_x     <= '0;
        end else if (load) begin
            // Also taken on the last pixel of a row, which keeps the stream gapless.
            pix_valid <= 1'b1;
            pix_x     <= '0;
        end else if (pix_valid) begin
            pix_x <= pix_x + 1'b1;
            if (pix_x == coord_w'(canvas_dim - 1)) begin
                pix_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            row_shift <= row_data;
            pix_y     <= load_row;
        end else if (pix_valid) begin
            row_shift <= row_shift >> pix_w;
        end
    end

endmodule

// File: design/row_fetch.sv
`timescale 1ns/100ps

module row_fetch (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              frame_start,
    output logic                              rd,
    output logic [canvas_pkg::coord_w-1:0]    rd_row,
    output logic                              load,
    output logic [canvas_pkg::coord_w-1:0]    load_row,
    output logic                              scan_busy
);
    import canvas_pkg::*;

    scan_state_e state;

    // Tracks pix_x of the serializer output, starting at 62 so that
    // the first pixel of the frame lands on position 0.
    logic [coord_w-1:0] pos;

    assign scan_busy = (state == scan_active);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= scan_idle;
            rd    <= 1'b0;
            load  <= 1'b0;
        end else begin
            rd   <= 1'b0;
            load <= rd;
            case (state)
                scan_idle: begin
                    if (frame_start) begin
                        state <= scan_active;
                        rd    <= 1'b1;
                    end
                end
                scan_active: begin
                    if (pos == coord_w'(canvas_dim - 3) && rd_row != coord_w'(canvas_dim - 1)) begin
                        rd <= 1'b1;
                    end
                    // Last pixel of the last row; no row load is pending here.
                    if (pos == coord_w'(canvas_dim - 1) && rd_row == coord_w'(canvas_dim - 1)
                            && !load) begin
                        state <= scan_idle;
                    end
                end
                default: begin
                    state <= scan_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        load_row <= rd_row;
        if (state == scan_idle) begin
            pos    <= coord_w'(canvas_dim - 2);
            rd_row <= '0;
        end else begin
            pos <= pos + 1'b1;
            if (pos == coord_w'(canvas_dim - 3) && rd_row != coord_w'(canvas_dim - 1)) begin
                rd_row <= rd_row + 1'b1;
            end
        end
    end

endmodule

// File: design/draw_engine.sv
`timescale 1ns/100ps

module draw_engine (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cmd_valid,
    input  canvas_pkg::draw_op_e              cmd_op,
    input  logic [canvas_pkg::coord_w-1:0]    cmd_x,
    input  logic [canvas_pkg::coord_w-1:0]    cmd_y,
    input  logic [canvas_pkg::coord_w-1:0]    cmd_x_end,
    input  logic [canvas_pkg::pix_w-1:0]      cmd_color,
    output logic                              busy,
    output logic                              wr,
    output logic [canvas_pkg::addr_w-1:0]     wr_addr,
    output logic [canvas_pkg::pix_w-1:0]      wr_data
);
    import canvas_pkg::*;

    draw_state_e state;

    // Last address the run state writes before returning to idle.
    logic [addr_w-1:0] end_addr;
    logic [coord_w-1:0] hline_end;

    // A reversed span collapses to the start pixel.
    assign hline_end = (cmd_x_end < cmd_x) ? cmd_x : cmd_x_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= draw_idle;
            busy  <= 1'b0;
            wr    <= 1'b0;
        end else begin
            case (state)
                draw_idle: begin
                    wr <= 1'b0;
                    if (cmd_valid) begin
                        case (cmd_op)
                            // A plot is a single write and never raises busy.
                            op_plot: begin
                                wr <= 1'b1;
                            end
                            op_hline, op_clear: begin
                                wr    <= 1'b1;
                                busy  <= 1'b1;
                                state <= draw_run;
                            end
                            default: begin
                                wr <= 1'b0;
                            end
                        endcase
                    end
                end
                draw_run: begin
                    if (wr_addr == end_addr) begin
                        wr    <= 1'b0;
                        busy  <= 1'b0;
                        state <= draw_idle;
                    end
                end
                default: begin
                    state <= draw_idle;
                end
            endcase
        end
    end

    // Address and colour of the write in flight.
    always_ff @(posedge clk) begin
        if (state == draw_idle) begin
            if (cmd_valid) begin
                wr_data <= cmd_color;
                if (cmd_op == op_clear) begin
                    wr_addr  <= '0;
                    end_addr <= '1;
                end else begin
                    wr_addr  <= {cmd_y, cmd_x};
                    end_addr <= {cmd_y, hline_end};
                end
            end
        end else begin
            // Overruns past end_addr once, harmless since wr is low by then.
            wr_addr <= wr_addr + 1'b1;
        end
    end

endmodule

// File: design/canvas_vram.sv
`timescale 1ns/100ps

module canvas_vram (
    input  logic                              clk,
    input  logic                              wr,
    input  logic [canvas_pkg::addr_w-1:0]     wr_addr,
    input  logic [canvas_pkg::pix_w-1:0]      wr_data,
    input  logic                              rd,
    input  logic [canvas_pkg::coord_w-1:0]    rd_row,
    output logic [canvas_pkg::row_w-1:0]      row_data
);
    import canvas_pkg::*;

    logic [pix_w-1:0] mem [0:canvas_dim*canvas_dim-1];

    // All 64 pixels of the addressed row, pixel 0 in the lowest byte.
    wire [row_w-1:0] row_next;

    for (genvar k = 0; k < canvas_dim; k++) begin : g_lane
        assign row_next[k*pix_w +: pix_w] = mem[{rd_row, coord_w'(k)}];
    end

    // A read in the same cycle as a write to that pixel sees the old value.
    always_ff @(posedge clk) begin
        if (rd) begin
            row_data <= row_next;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

// File: design/canvas_pkg.sv
package canvas_pkg;

    // Frame geometry. The canvas is square, so one size serves for rows and columns.
    localparam int canvas_dim = 64;
    localparam int coord_w    = 6;
    localparam int pix_w      = 8;

    // Pixel address is {y, x}, so a row occupies one aligned block of 64 addresses.
    localparam int addr_w = 12;
    localparam int row_w  = 512;

    // Drawing commands. The fourth encoding is unused and treated as a no-op.
    typedef enum logic [1:0] {
        op_plot  = 2'd0,
        op_hline = 2'd1,
        op_clear = 2'd2
    } draw_op_e;

    typedef enum logic {
        draw_idle = 1'b0,
        draw_run  = 1'b1
    } draw_state_e;

    typedef enum logic {
        scan_idle   = 1'b0,
        scan_active = 1'b1
    } scan_state_e;

endpackage
